// File: rv_pkg.sv
package rv_pkg;

    // major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT,
        ALU_EQ,  // branch compares
        ALU_NE,
        ALU_LT
    } alu_op_t;

    // machine mode CSRs plus the user time counter
    typedef enum logic [11:0] {
        CSR_MSTATUS = 12'h300,
        CSR_MIE     = 12'h304,
        CSR_MTVEC   = 12'h305,
        CSR_MEPC    = 12'h341,
        CSR_MCAUSE  = 12'h342,
        CSR_TIME    = 12'hc01,
        CSR_TIMEH   = 12'hc81
    } csr_addr_t;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,    // csr and system instructions
        ST_MEM,
        ST_WRITEBACK,
        ST_SLEEP,
        ST_HALTED
    } core_state_t;

    // interrupt causes carry bit 31
    localparam logic [31:0] CAUSE_SOFT    = 32'h8000_0003;
    localparam logic [31:0] CAUSE_TIMER   = 32'h8000_0007;
    localparam logic [31:0] CAUSE_EXT     = 32'h8000_000b;
    localparam logic [31:0] CAUSE_BUS_ERR = 32'h0000_0005;  // load access fault

endpackage

// File: rv_alu.sv
`timescale 1ns/1ns

module rv_alu (
    input  rv_pkg::alu_op_t op,
    input  logic [31:0]     a,
    input  logic [31:0]     b,
    output logic [31:0]     result,
    output logic            taken
);

    logic lt;

    assign lt = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            rv_pkg::ALU_EQ: taken = (a == b);
            rv_pkg::ALU_NE: taken = (a != b);
            rv_pkg::ALU_LT: taken = lt;
            default:        taken = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            rv_pkg::ALU_SUB: result = a - b;
            rv_pkg::ALU_AND: result = a & b;
            rv_pkg::ALU_OR:  result = a | b;
            rv_pkg::ALU_XOR: result = a ^ b;
            rv_pkg::ALU_SLL: result = a << b[4:0];
            rv_pkg::ALU_SRL: result = a >> b[4:0];  // logical only
            rv_pkg::ALU_SLT: result = {31'd0, lt};
            rv_pkg::ALU_EQ,
            rv_pkg::ALU_NE,
            rv_pkg::ALU_LT:  result = {31'd0, taken};
            default:         result = a + b;
        endcase
    end

endmodule

// File: rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile (
    input  logic        CLK,
    input  logic        rst,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        we,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [1:31];  // x0 has no storage

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= 32'd0;
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wd;
        end
    end

    assign rd1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rd2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

// File: rv_decode.sv
`timescale 1ns/1ns

module rv_decode (
    input  logic [31:0]       instr,
    output rv_pkg::opcode_t   opcode,
    output logic [4:0]        rd,
    output logic [4:0]        rs1,
    output logic [4:0]        rs2,
    output logic [31:0]       imm,
    output rv_pkg::alu_op_t   alu_op,
    output logic              use_imm,
    output logic              reg_write,
    output logic              is_load,
    output logic              is_store,
    output logic              is_byte,
    output logic              is_branch,
    output logic              is_jal,
    output logic              is_jalr,
    output logic              is_csr,
    output logic              csr_set,
    output rv_pkg::csr_addr_t csr_addr,
    output logic              is_mret,
    output logic              is_wfi,
    output logic              is_ebreak
);

    logic [2:0]  funct3;
    logic [11:0] funct12;
    logic        is_priv;

    assign opcode   = rv_pkg::opcode_t'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct12  = instr[31:20];
    assign rd       = instr[11:7];
    assign rs1      = instr[19:15];
    assign rs2      = instr[24:20];
    assign csr_addr = rv_pkg::csr_addr_t'(funct12);

    always_comb begin
        case (opcode)
            rv_pkg::OPC_LUI:    imm = {instr[31:12], 12'd0};
            rv_pkg::OPC_STORE:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rv_pkg::OPC_BRANCH: imm = {{19{instr[31]}}, instr[31], instr[7],
                                       instr[30:25], instr[11:8], 1'b0};
            rv_pkg::OPC_JAL:    imm = {{11{instr[31]}}, instr[31], instr[19:12],
                                       instr[20], instr[30:21], 1'b0};
            default:            imm = {{20{instr[31]}}, funct12};  // I type
        endcase
    end

    always_comb begin
        alu_op = rv_pkg::ALU_ADD;
        if (opcode == rv_pkg::OPC_OP || opcode == rv_pkg::OPC_OP_IMM) begin
            case (funct3)
                3'b000: alu_op = (opcode == rv_pkg::OPC_OP && instr[30]) ? rv_pkg::ALU_SUB
                                                                         : rv_pkg::ALU_ADD;
                3'b001: alu_op = rv_pkg::ALU_SLL;
                3'b010: alu_op = rv_pkg::ALU_SLT;
                3'b100: alu_op = rv_pkg::ALU_XOR;
                3'b101: alu_op = rv_pkg::ALU_SRL;
                3'b110: alu_op = rv_pkg::ALU_OR;
                3'b111: alu_op = rv_pkg::ALU_AND;
                default: ;
            endcase
        end else if (opcode == rv_pkg::OPC_BRANCH) begin
            case (funct3)
                3'b001:  alu_op = rv_pkg::ALU_NE;
                3'b100:  alu_op = rv_pkg::ALU_LT;
                default: alu_op = rv_pkg::ALU_EQ;
            endcase
        end
    end

    assign is_load   = (opcode == rv_pkg::OPC_LOAD);
    assign is_store  = (opcode == rv_pkg::OPC_STORE);
    assign is_byte   = is_store && funct3 == 3'b000;  // funct3 000 marks sb
    assign is_branch = (opcode == rv_pkg::OPC_BRANCH);
    assign is_jal    = (opcode == rv_pkg::OPC_JAL);
    assign is_jalr   = (opcode == rv_pkg::OPC_JALR);
    assign is_csr    = (opcode == rv_pkg::OPC_SYSTEM) && funct3 != 3'b000;
    assign csr_set   = funct3[1];  // csrrs
    assign is_priv   = (opcode == rv_pkg::OPC_SYSTEM) && funct3 == 3'b000;
    assign is_mret   = is_priv && funct12 == 12'h302;
    assign is_wfi    = is_priv && funct12 == 12'h105;
    assign is_ebreak = is_priv && funct12 == 12'h001;

    assign use_imm   = opcode inside {rv_pkg::OPC_LUI, rv_pkg::OPC_OP_IMM, rv_pkg::OPC_LOAD,
                                      rv_pkg::OPC_STORE, rv_pkg::OPC_JALR};
    assign reg_write = is_csr || opcode inside {rv_pkg::OPC_LUI, rv_pkg::OPC_OP_IMM,
                                                rv_pkg::OPC_OP, rv_pkg::OPC_LOAD,
                                                rv_pkg::OPC_JAL, rv_pkg::OPC_JALR};

endmodule

// File: rv_csr_irq.sv
`timescale 1ns/1ns

module rv_csr_irq (
    input  logic                CLK,
    input  logic                rst,
    input  logic [63:0]         mtime,
    input  logic                ext_int,
    input  logic                ext_int_clear,
    input  logic                soft_int,
    input  logic                soft_int_clear,
    input  logic                timer_int,
    input  logic                timer_int_clear,
    input  rv_pkg::core_state_t state,
    input  logic                csr_en,
    input  rv_pkg::csr_addr_t   csr_addr,
    input  logic                csr_set,
    input  logic [31:0]         csr_wdata,
    input  logic                trap_check,
    input  logic [31:0]         next_pc,
    input  logic                bus_err,
    input  logic [31:0]         err_pc,
    input  logic                mret,
    output logic [31:0]         csr_rdata,
    output logic                irq_take,
    output logic [31:0]         trap_vector,
    output logic [31:0]         mepc,
    output logic                wake
);

    logic        mstatus_mie, mstatus_mpie;
    logic [2:0]  pend, irq_en, active;  // bit 2 ext, 1 soft, 0 timer
    logic [31:0] mtvec, mcause, wval, cause;

    assign active      = pend & irq_en;
    assign irq_take    = trap_check & mstatus_mie & (|active);
    assign wake        = (state == rv_pkg::ST_SLEEP) & (|active);  // ignores mstatus
    assign trap_vector = {mtvec[31:2], 2'b00};
    assign wval        = csr_set ? (csr_rdata | csr_wdata) : csr_wdata;

    always_comb begin
        if (active[2])
            cause = rv_pkg::CAUSE_EXT;
        else if (active[1])
            cause = rv_pkg::CAUSE_SOFT;
        else
            cause = rv_pkg::CAUSE_TIMER;
    end

    always_comb begin
        case (csr_addr)
            rv_pkg::CSR_MSTATUS: csr_rdata = {24'd0, mstatus_mpie, 3'd0, mstatus_mie, 3'd0};
            rv_pkg::CSR_MIE:     csr_rdata = {20'd0, irq_en[2], 3'd0, irq_en[0], 3'd0,
                                              irq_en[1], 3'd0};
            rv_pkg::CSR_MTVEC:   csr_rdata = mtvec;
            rv_pkg::CSR_MEPC:    csr_rdata = mepc;
            rv_pkg::CSR_MCAUSE:  csr_rdata = mcause;
            rv_pkg::CSR_TIME:    csr_rdata = mtime[31:0];
            rv_pkg::CSR_TIMEH:   csr_rdata = mtime[63:32];
            default:             csr_rdata = 32'd0;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            pend         <= 3'd0;
            irq_en       <= 3'd0;
            mtvec        <= 32'd0;
            mepc         <= 32'd0;
            mcause       <= 32'd0;
        end else begin
            // sticky bits where a clear beats a new request
            pend <= ~{ext_int_clear, soft_int_clear, timer_int_clear}
                    & (pend | {ext_int, soft_int, timer_int});

            if (bus_err || irq_take) begin
                mepc         <= bus_err ? err_pc : next_pc;
                mcause       <= bus_err ? rv_pkg::CAUSE_BUS_ERR : cause;
                mstatus_mpie <= mstatus_mie;
                mstatus_mie  <= 1'b0;
            end else if (mret) begin
                mstatus_mie  <= mstatus_mpie;
                mstatus_mpie <= 1'b1;
            end else if (csr_en) begin
                case (csr_addr)
                    rv_pkg::CSR_MSTATUS: begin
                        mstatus_mie  <= wval[3];
                        mstatus_mpie <= wval[7];
                    end
                    rv_pkg::CSR_MIE:    irq_en <= {wval[11], wval[3], wval[7]};
                    rv_pkg::CSR_MTVEC:  mtvec  <= wval;
                    rv_pkg::CSR_MEPC:   mepc   <= wval;
                    rv_pkg::CSR_MCAUSE: mcause <= wval;
                    default: ;  // time is read only
                endcase
            end
        end
    end

endmodule

// File: rv_core.sv
`timescale 1ns/1ns

module rv_core #(
    parameter logic [31:0] RESET_PC = 32'h80000000
) (
    input  logic        CLK,
    input  logic        rst,
    input  logic [63:0] mtime,
    output logic        wfi,
    output logic        halt,
    input  logic        busy,
    input  logic        error,
    input  logic [31:0] rdata,
    output logic        ren,
    output logic        wen,
    output logic [3:0]  byte_en,
    output logic [31:0] addr,
    output logic [31:0] wdata,
    input  logic        ext_int,
    input  logic        ext_int_clear,
    input  logic        soft_int,
    input  logic        soft_int_clear,
    input  logic        timer_int,
    input  logic        timer_int_clear
);

    rv_pkg::core_state_t state;
    logic [31:0] pc, ir, npc, res, ld_data;

    rv_pkg::opcode_t   opcode;
    rv_pkg::alu_op_t   alu_op;
    rv_pkg::csr_addr_t csr_addr;
    logic [4:0]  rd, rs1, rs2;
    logic [31:0] imm;
    logic use_imm, reg_write, is_load, is_store, is_byte, is_branch, is_jal, is_jalr;
    logic is_csr, csr_set, is_mret, is_wfi, is_ebreak;

    logic [31:0] rd1, rd2, alu_a, alu_b, alu_res, pc_plus4, pc_imm;
    logic [31:0] csr_rdata, trap_vector, mepc;
    logic taken, irq_take, wake, bus_err;

    assign alu_a    = (opcode == rv_pkg::OPC_LUI) ? 32'd0 : rd1;  // lui is 0 + imm
    assign alu_b    = use_imm ? imm : rd2;
    assign pc_plus4 = pc + 32'd4;
    assign pc_imm   = pc + imm;
    assign bus_err  = (ren | wen) & ~busy & error;
    assign wfi      = (state == rv_pkg::ST_SLEEP);
    assign halt     = (state == rv_pkg::ST_HALTED);

    rv_decode dec (
        .instr(ir), .opcode(opcode), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm),
        .alu_op(alu_op), .use_imm(use_imm), .reg_write(reg_write),
        .is_load(is_load), .is_store(is_store), .is_byte(is_byte),
        .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr),
        .is_csr(is_csr), .csr_set(csr_set), .csr_addr(csr_addr),
        .is_mret(is_mret), .is_wfi(is_wfi), .is_ebreak(is_ebreak)
    );

    rv_regfile rf (
        .CLK(CLK), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd),
        .we(state == rv_pkg::ST_WRITEBACK && reg_write),
        .wd(is_load ? ld_data : res),
        .rd1(rd1), .rd2(rd2)
    );

    rv_alu alu (
        .op(alu_op), .a(alu_a), .b(alu_b), .result(alu_res), .taken(taken)
    );

    rv_csr_irq csr (
        .CLK(CLK), .rst(rst), .mtime(mtime),
        .ext_int(ext_int), .ext_int_clear(ext_int_clear),
        .soft_int(soft_int), .soft_int_clear(soft_int_clear),
        .timer_int(timer_int), .timer_int_clear(timer_int_clear),
        .state(state),
        .csr_en(state == rv_pkg::ST_EXECUTE && is_csr),
        .csr_addr(csr_addr), .csr_set(csr_set), .csr_wdata(rd1),
        .trap_check(state == rv_pkg::ST_WRITEBACK), .next_pc(npc),
        .bus_err(bus_err), .err_pc(pc),
        .mret(state == rv_pkg::ST_EXECUTE && is_mret),
        .csr_rdata(csr_rdata), .irq_take(irq_take), .trap_vector(trap_vector),
        .mepc(mepc), .wake(wake)
    );

    always_ff @(posedge CLK) begin
        if (rst) begin
            state   <= rv_pkg::ST_FETCH;
            pc      <= RESET_PC;
            ren     <= 1'b0;
            wen     <= 1'b0;
            byte_en <= 4'b0000;
            addr    <= 32'd0;
            wdata   <= 32'd0;
        end else begin
            case (state)
                rv_pkg::ST_FETCH: begin
                    if (!ren) begin  // only right after reset
                        ren     <= 1'b1;
                        addr    <= pc;
                        byte_en <= 4'b1111;
                    end else if (!busy) begin
                        ren   <= 1'b0;
                        ir    <= rdata;
                        state <= error ? rv_pkg::ST_HALTED : rv_pkg::ST_DECODE;
                    end
                end
                rv_pkg::ST_DECODE: begin
                    res <= (is_jal | is_jalr) ? pc_plus4 : alu_res;
                    if (is_jal || (is_branch && taken))
                        npc <= pc_imm;
                    else if (is_jalr)
                        npc <= {alu_res[31:1], 1'b0};
                    else
                        npc <= pc_plus4;

                    if (is_load || is_store) begin
                        ren     <= is_load;
                        wen     <= is_store;
                        addr    <= alu_res;
                        byte_en <= is_byte ? 4'b0001 << alu_res[1:0] : 4'b1111;
                        // sb puts the byte in its lane
                        wdata   <= is_byte ? {24'd0, rd2[7:0]} << {alu_res[1:0], 3'b000} : rd2;
                        state   <= rv_pkg::ST_MEM;
                    end else if (is_csr || is_mret || is_wfi || is_ebreak) begin
                        state <= rv_pkg::ST_EXECUTE;
                    end else begin
                        state <= rv_pkg::ST_WRITEBACK;
                    end
                end
                rv_pkg::ST_EXECUTE: begin
                    res <= csr_rdata;  // old value goes to rd
                    if (is_mret)
                        npc <= mepc;
                    if (is_ebreak)
                        state <= rv_pkg::ST_HALTED;
                    else if (is_wfi)
                        state <= rv_pkg::ST_SLEEP;
                    else
                        state <= rv_pkg::ST_WRITEBACK;
                end
                rv_pkg::ST_MEM: begin
                    if (!busy) begin
                        ren     <= 1'b0;
                        wen     <= 1'b0;
                        ld_data <= rdata;
                        state   <= error ? rv_pkg::ST_HALTED : rv_pkg::ST_WRITEBACK;
                    end
                end
                rv_pkg::ST_WRITEBACK: begin
                    // interrupt redirects the next fetch
                    pc      <= irq_take ? trap_vector : npc;
                    addr    <= irq_take ? trap_vector : npc;
                    ren     <= 1'b1;
                    byte_en <= 4'b1111;
                    state   <= rv_pkg::ST_FETCH;
                end
                rv_pkg::ST_SLEEP: begin
                    if (wake)
                        state <= rv_pkg::ST_WRITEBACK;
                end
                default: ;  // halted until reset
            endcase
        end
    end

endmodule

// File: top_core.sv
`timescale 1ns/1ns

module top_core #(
    parameter logic [31:0] RESET_PC = 32'h80000000
) (
    input  logic        CLK,
    input  logic        rst,
    input  logic [63:0] mtime,
    output logic        wfi,
    output logic        halt,
    // generic bus
    input  logic        busy,
    input  logic        error,
    input  logic [31:0] rdata,
    output logic        ren,
    output logic        wen,
    output logic [3:0]  byte_en,
    output logic [31:0] addr,
    output logic [31:0] wdata,
    // interrupt sources
    input  logic        ext_int,
    input  logic        ext_int_clear,
    input  logic        soft_int,
    input  logic        soft_int_clear,
    input  logic        timer_int,
    input  logic        timer_int_clear
);

    rv_core #(
        .RESET_PC(RESET_PC)
    ) core (
        .CLK(CLK), .rst(rst), .mtime(mtime), .wfi(wfi), .halt(halt),
        .busy(busy), .error(error), .rdata(rdata),
        .ren(ren), .wen(wen), .byte_en(byte_en), .addr(addr), .wdata(wdata),
        .ext_int(ext_int), .ext_int_clear(ext_int_clear),
        .soft_int(soft_int), .soft_int_clear(soft_int_clear),
        .timer_int(timer_int), .timer_int_clear(timer_int_clear)
    );

endmodule

// File: tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

localparam logic [31:0] DATA_BASE = 32'h8000_0400;
localparam logic [31:0] HANDLER   = 32'h8000_0100;

int          pc_i;
int          jal_at;      // word index of the jal in the alu program
logic [67:0] exp_q[$];    // {addr, data, byte_en}

function automatic logic [31:0] enc_i(input logic [11:0] imm, input int rs1, input int f3,
                                      input int rd, input logic [6:0] op);
    return {imm, rs1[4:0], f3[2:0], rd[4:0], op};
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                      input int f3, input int rd);
    return {f7, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input int rs2, input int f3);
    return {imm[11:5], rs2[4:0], 5'd10, f3[2:0], imm[4:0], 7'b0100011};  // base is x10
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input int rs2, input int rs1,
                                      input int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
endfunction

task automatic emit(input logic [31:0] w);
    mem[pc_i] = w;
    pc_i++;
endtask

task automatic load_const(input int rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = (v + 32'h800) >> 12;  // addi sign-extends the low part
    emit({hi[19:0], rd[4:0], 7'b0110111});
    emit(enc_i(v[11:0], rd, 0, rd, 7'b0010011));
endtask

function automatic void push_store(input logic [31:0] a, input logic [31:0] d,
                                   input logic [3:0] be);
    exp_q.push_back({a, d, be});
endfunction

// expected store traffic of the alu program
function automatic void ref_alu_stores(input logic [31:0] a, input logic [31:0] b,
                                       input int n, input logic [7:0] r[4]);
    logic [31:0] base;
    base = 32'h8000_0000 + 32'(jal_at) * 4;
    push_store(DATA_BASE + 0, a + b, 4'hf);
    push_store(DATA_BASE + 4, a - b, 4'hf);
    push_store(DATA_BASE + 8, a & b, 4'hf);
    push_store(DATA_BASE + 12, a | b, 4'hf);
    push_store(DATA_BASE + 16, a ^ b, 4'hf);
    push_store(DATA_BASE + 20, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0, 4'hf);
    push_store(DATA_BASE + 24, a << 5, 4'hf);
    push_store(DATA_BASE + 28, a >> 7, 4'hf);
    push_store(DATA_BASE + 32, 32'(3 * n), 4'hf);
    push_store(DATA_BASE + 36, ($signed(a) < $signed(b)) ? 32'd1 : 32'd2, 4'hf);
    push_store(DATA_BASE + 40, base + 4, 4'hf);
    push_store(DATA_BASE + 44, base + 16, 4'hf);
    for (int i = 0; i < 4; i++)
        push_store(DATA_BASE + 48 + i, 32'(r[i]) << (8 * i), 4'b0001 << i);
    push_store(DATA_BASE + 52, {r[3], r[2], r[1], r[0]}, 4'hf);
endfunction

// handler traffic for one interrupt where src 0 is ext, 1 soft and 2 timer
function automatic void ref_irq_stores(input int src, input logic [63:0] t);
    logic [31:0] cause;
    cause = (src == 0) ? rv_pkg::CAUSE_EXT : (src == 1) ? rv_pkg::CAUSE_SOFT
                                                        : rv_pkg::CAUSE_TIMER;
    push_store(DATA_BASE + 64, cause, 4'hf);
    push_store(DATA_BASE + 68, 32'h8000_002c + 32'(src) * 4, 4'hf);  // word after the wfi
    push_store(DATA_BASE + 72, t[31:0], 4'hf);
    push_store(DATA_BASE + 76, 32'd0, 4'hf);
endfunction

`endif

// File: tb_top_core.sv
`timescale 1ns/1ns

module tb_top_core;

    logic CLK = 1'b0, rst, busy, error, ren, wen, wfi, halt;
    logic [63:0] mtime;
    logic [31:0] rdata, addr, wdata, err_addr;
    logic [3:0]  byte_en;
    logic ext_int, ext_int_clear, soft_int, soft_int_clear, timer_int, timer_int_clear;
    logic [31:0] mem [0:511];
    logic [67:0] got[$];
    logic [2:0]  clr;
    string test_name;
    int err_count, wait_left;
    bit busy_mode, idle;

    `include "tb_programs.svh"

    always #4 CLK = ~CLK;

    top_core #(.RESET_PC(32'h8000_0000)) top_core_inst (
        .CLK(CLK), .rst(rst), .mtime(mtime), .wfi(wfi), .halt(halt),
        .busy(busy), .error(error), .rdata(rdata), .ren(ren), .wen(wen),
        .byte_en(byte_en), .addr(addr), .wdata(wdata),
        .ext_int(ext_int), .ext_int_clear(ext_int_clear),
        .soft_int(soft_int), .soft_int_clear(soft_int_clear),
        .timer_int(timer_int), .timer_int_clear(timer_int_clear)
    );

    task automatic check(input string name, input logic [67:0] exp, input logic [67:0] act);
        if (exp !== act) begin
            err_count++;
            $display("FAILED %s expected %h actual %h", name, exp, act);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // memory model drives busy, error and rdata 1 ns after the edge
    always @(posedge CLK) begin
        if (!rst && (ren || wen) && !busy) begin
            if (wen) begin
                for (int j = 0; j < 4; j++)
                    if (byte_en[j])
                        mem[addr[10:2]][8*j +: 8] = wdata[8*j +: 8];
                got.push_back({addr, wdata, byte_en});
                if (addr == DATA_BASE + 76)
                    clr = {timer_int, soft_int, ext_int};  // handler done
            end
            idle = 1'b1;
        end
        #1;
        {timer_int_clear, soft_int_clear, ext_int_clear} = clr;
        {timer_int, soft_int, ext_int} = {timer_int, soft_int, ext_int} & ~clr;
        clr = 3'b000;
        if (rst || !(ren || wen)) begin
            busy = 1'b0;
            error = 1'b0;
            idle = 1'b1;
        end else begin
            if (idle)
                wait_left = busy_mode ? $urandom_range(3, 0) : 0;
            idle = 1'b0;
            busy = (wait_left != 0);
            if (wait_left > 0)
                wait_left--;
            rdata = mem[addr[10:2]];
            error = !busy && addr == err_addr;
        end
    end

    // compare process
    always @(negedge CLK) begin
        while (got.size() > 0) begin
            if (exp_q.size() == 0) begin
                $display("store to %h that no program expects", got[0][67:36]);
                $display("Errors found");
                $fatal(1);
            end
            check(test_name, exp_q.pop_front(), got.pop_front());
        end
    end

    function automatic logic ready(input int what);
        case (what)
            0: return wfi;
            1: return halt;
            default: return exp_q.size() == 0 && got.size() == 0;
        endcase
    endfunction

    task automatic wait_for(input int what, input string desc);
        int n;
        n = 0;
        while (!ready(what)) begin
            @(posedge CLK);
            #1;
            n++;
            if (n > 4000) begin
                $display("timeout in %s waiting for %s", test_name, desc);
                $display("Errors found");
                $fatal(1);
            end
        end
    endtask

    task automatic clear_mem();
        for (int i = 0; i < 512; i++)
            mem[i] = 32'h5a5a_0000 ^ (i * 32'h0001_0101);
        pc_i = 0;
        exp_q.delete();
    endtask

    task automatic start_run(input string name);
        test_name = name;
        rst = 1'b1;
        repeat (16) begin
            @(posedge CLK);
            #1;
            check({test_name, " reset"}, 68'd0, {wen, wfi, halt});
        end
        rst = 1'b0;
        @(posedge CLK);
        #1;
        check({test_name, " first fetch"},
              {1'b1, 1'b0, 1'b0, 1'b0, 4'hf, 32'h8000_0000},
              {ren, wen, wfi, halt, byte_en, addr});
    endtask

    task automatic end_halted();
        wait_for(1, "halt");
        wait_for(2, "stores");
        repeat (20) begin
            @(posedge CLK);
            #1;
            check({test_name, " halt"}, 68'h1, {ren, wen, halt});
        end
    endtask

    task automatic build_alu(input logic [31:0] a, input logic [31:0] b, input int n,
                             input logic [7:0] r[4]);
        load_const(1, a);
        load_const(2, b);
        load_const(10, DATA_BASE);
        emit(enc_r(7'h00, 2, 1, 0, 3));
        emit(enc_s(0, 3, 2));
        emit(enc_r(7'h20, 2, 1, 0, 3));
        emit(enc_s(4, 3, 2));
        emit(enc_r(7'h00, 2, 1, 7, 3));
        emit(enc_s(8, 3, 2));
        emit(enc_r(7'h00, 2, 1, 6, 3));
        emit(enc_s(12, 3, 2));
        emit(enc_r(7'h00, 2, 1, 4, 3));
        emit(enc_s(16, 3, 2));
        emit(enc_r(7'h00, 2, 1, 2, 3));
        emit(enc_s(20, 3, 2));
        emit(enc_i(5, 1, 1, 3, 7'b0010011));   // slli
        emit(enc_s(24, 3, 2));
        emit(enc_i(7, 1, 5, 3, 7'b0010011));   // srli
        emit(enc_s(28, 3, 2));
        emit(enc_i(12'(n), 0, 0, 4, 7'b0010011));
        emit(enc_i(0, 0, 0, 5, 7'b0010011));
        emit(enc_i(3, 5, 0, 5, 7'b0010011));   // loop body
        emit(enc_i(12'hfff, 4, 0, 4, 7'b0010011));
        emit(enc_b(-8, 0, 4, 1));
        emit(enc_s(32, 5, 2));
        emit(enc_i(1, 0, 0, 6, 7'b0010011));
        emit(enc_b(8, 2, 1, 4));
        emit(enc_i(2, 0, 0, 6, 7'b0010011));
        emit(enc_s(36, 6, 2));
        jal_at = pc_i;
        emit(enc_j(8, 7));
        emit(enc_i(0, 0, 0, 7, 7'b0010011));   // skipped
        emit(enc_s(40, 7, 2));
        emit(enc_i(16, 7, 0, 8, 7'b1100111));  // jalr
        emit(enc_i(0, 0, 0, 8, 7'b0010011));   // skipped
        emit(enc_s(44, 8, 2));
        for (int i = 0; i < 4; i++) begin
            emit(enc_i(12'(r[i]), 0, 0, 9, 7'b0010011));
            emit(enc_s(12'(48 + i), 9, 0));
        end
        emit(enc_i(48, 10, 2, 11, 7'b0000011));
        emit(enc_s(52, 11, 2));
        emit(32'h0010_0073);                   // ebreak
    endtask

    task automatic build_irq();
        load_const(10, DATA_BASE);
        load_const(1, HANDLER);
        emit(enc_i(12'h305, 1, 1, 0, 7'b1110011));
        load_const(1, 32'h888);                // ext, timer and soft enables
        emit(enc_i(12'h304, 1, 1, 0, 7'b1110011));
        emit(enc_i(8, 0, 0, 1, 7'b0010011));
        emit(enc_i(12'h300, 1, 2, 0, 7'b1110011));
        repeat (3)
            emit(32'h1050_0073);               // wfi at words 10 to 12
        emit(32'h0010_0073);
        pc_i = 64;
        emit(enc_i(12'h342, 0, 2, 20, 7'b1110011));
        emit(enc_s(64, 20, 2));
        emit(enc_i(12'h341, 0, 2, 21, 7'b1110011));
        emit(enc_s(68, 21, 2));
        emit(enc_i(12'hc01, 0, 2, 22, 7'b1110011));
        emit(enc_s(72, 22, 2));
        emit(enc_s(76, 0, 2));                 // asks the testbench to clear the source
        emit(32'h3020_0073);
    endtask

    initial begin
        logic [31:0] a, b;
        logic [7:0]  r[4];
        int n;
        void'($urandom(32'hbfdbc65d));
        {rst, busy, error, rdata, mtime, clr} = {1'b1, 1'b0, 1'b0, 32'd0, 64'd0, 3'd0};
        {ext_int, ext_int_clear, soft_int, soft_int_clear} = 4'd0;
        {timer_int, timer_int_clear} = 2'd0;
        err_addr = 32'hffff_fffc;
        err_count = 0;
        a = $urandom;
        b = $urandom;
        n = $urandom_range(4, 1);
        for (int i = 0; i < 4; i++)
            r[i] = $urandom_range(255, 0);
        for (int pass = 0; pass < 2; pass++) begin
            busy_mode = pass;
            clear_mem();
            build_alu(a, b, n, r);
            ref_alu_stores(a, b, n, r);
            start_run(pass ? "alu_busy" : "alu");
            end_halted();
        end

        busy_mode = 1'b1;
        clear_mem();
        build_irq();
        start_run("irq");
        for (int src = 0; src < 3; src++) begin
            wait_for(0, "wfi");
            mtime = {$urandom, $urandom};
            ref_irq_stores(src, mtime);
            {timer_int, soft_int, ext_int} = 3'b001 << src;
            wait_for(2, "handler stores");
        end
        end_halted();

        clear_mem();
        load_const(10, DATA_BASE);
        emit(enc_i(0, 10, 2, 1, 7'b0000011));  // lw from the faulting word
        emit(enc_s(4, 0, 2));                  // stores only if the fault is missed
        emit(32'h0010_0073);
        err_addr = DATA_BASE;
        start_run("bus_error");
        end_halted();

        if (err_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1);
        end
    end

endmodule

// File: filelist.f
+incdir+.
rv_pkg.sv
rv_alu.sv
rv_regfile.sv
rv_decode.sv
rv_csr_irq.sv
rv_core.sv
top_core.sv
tb_top_core.sv
